//--- design/rv_front_config.svh
`ifndef RV_FRONT_CONFIG_SVH
`define RV_FRONT_CONFIG_SVH

// ==============================
// Widths
// ==============================

`define ADDR_W 32
`define WORD_W 32

// ==============================
// Cache and fetch
// ==============================

`define LINES 64               // Direct mapped, one word per line.
`define RESET_PC 32'h0000_0000
`define OP_NOP 32'h00000013    // addi x0, x0, 0.

`endif

//--- design/rv_front_pkg.sv
package rv_front_pkg;

    // ==============================
    // Decode classes
    // ==============================

    // Opcode class of one issue slot.
    typedef enum logic [2:0] {
        OPC_NOP    = 3'd0,  // Squashed or empty slot.
        OPC_ALU    = 3'd1,  // OP and OP-IMM.
        OPC_LOAD   = 3'd2,
        OPC_STORE  = 3'd3,
        OPC_BRANCH = 3'd4,
        OPC_JAL    = 3'd5,
        OPC_JALR   = 3'd6,
        OPC_OTHER  = 3'd7   // LUI, AUIPC, system and the rest.
    } op_class_e;

    // ==============================
    // Cache refill
    // ==============================

    // Refill sequence, one line per miss.
    typedef enum logic [1:0] {
        RF_IDLE  = 2'd0,  // Looking for a miss.
        RF_WAIT  = 2'd1,  // Request out, waiting on memory.
        RF_WRITE = 2'd2   // Word captured, line written.
    } refill_state_e;

endpackage

//--- design/icache.sv
`include "rv_front_config.svh"

module icache import rv_front_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    // Fetch side.
    input  logic [`ADDR_W-1:0] pcx,
    input  logic [`ADDR_W-1:0] pcy,
    output logic               hitx,
    output logic               hity,
    output logic [`WORD_W-1:0] instx,
    output logic [`WORD_W-1:0] insty,
    // Refill side.
    output logic               mem_req,
    output logic [`ADDR_W-1:0] mem_addr,
    input  logic               mem_valid,
    input  logic [`WORD_W-1:0] mem_data
);

    localparam int IDX_W = $clog2(`LINES);
    localparam int TAG_W = `ADDR_W - IDX_W - 2;

    logic [TAG_W-1:0]   tag_mem  [`LINES];
    logic [`WORD_W-1:0] data_mem [`LINES];
    logic [`LINES-1:0]  line_valid;

    refill_state_e      state;
    logic [`WORD_W-1:0] fill_data;

    logic [IDX_W-1:0] idx_x;
    logic [IDX_W-1:0] idx_y;
    logic [IDX_W-1:0] idx_fill;

    // ==============================
    // Read ports
    // ==============================

    assign idx_x    = pcx[IDX_W+1:2];
    assign idx_y    = pcy[IDX_W+1:2];
    assign idx_fill = mem_addr[IDX_W+1:2];

    assign hitx  = line_valid[idx_x] && (tag_mem[idx_x] == pcx[`ADDR_W-1:IDX_W+2]);
    assign hity  = line_valid[idx_y] && (tag_mem[idx_y] == pcy[`ADDR_W-1:IDX_W+2]);
    assign instx = data_mem[idx_x];
    assign insty = data_mem[idx_y];

    // ==============================
    // Refill FSM
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RF_IDLE;
            mem_req    <= 1'b0;
            mem_addr   <= '0;
            line_valid <= '0;
        end else begin
            case (state)
                RF_IDLE: begin
                    if (rdy && (!hitx || !hity)) begin
                        mem_req  <= 1'b1;
                        // Slot x first, then y.
                        mem_addr <= {(hitx ? pcy[`ADDR_W-1:2] : pcx[`ADDR_W-1:2]), 2'b00};
                        state    <= RF_WAIT;
                    end
                end
                RF_WAIT: begin
                    if (mem_valid) begin  // Pulse is taken even while stalled.
                        mem_req <= 1'b0;
                        state   <= RF_WRITE;
                    end
                end
                RF_WRITE: begin
                    if (rdy) begin
                        line_valid[idx_fill] <= 1'b1;
                        state                <= RF_IDLE;
                    end
                end
                default: state <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RF_WAIT && mem_valid) begin
            fill_data <= mem_data;
        end
        if (state == RF_WRITE && rdy) begin
            data_mem[idx_fill] <= fill_data;
            tag_mem[idx_fill]  <= mem_addr[`ADDR_W-1:IDX_W+2];
        end
    end

    // Memory sees one address per request.
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req && !mem_valid) |=> $stable(mem_addr));

endmodule

//--- design/cpu_if.sv
`include "rv_front_config.svh"

module cpu_if (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    // From the cache.
    input  logic               hitx,
    input  logic               hity,
    input  logic [`WORD_W-1:0] instx,
    input  logic [`WORD_W-1:0] insty,
    // To the cache.
    output logic [`ADDR_W-1:0] pcx,
    output logic [`ADDR_W-1:0] pcy,
    // From the branch unit.
    input  logic               en_jmp0,
    input  logic [`ADDR_W-1:0] jmp_addr0,
    input  logic               en_jmp1,
    input  logic [`ADDR_W-1:0] jmp_addr1,
    // To the decoder.
    input  logic               issue0,
    input  logic               issue1,
    output logic [`ADDR_W-1:0] pc0,
    output logic [`ADDR_W-1:0] pc1,
    output logic               hitx_q,
    output logic               hity_q,
    output logic [`WORD_W-1:0] instx_q,
    output logic [`WORD_W-1:0] insty_q
);

    logic               jmp_stall;
    logic               en_jmp;
    logic [`ADDR_W-1:0] jmp_addr;
    logic [`WORD_W-1:0] wordx;
    logic [`WORD_W-1:0] wordy;
    logic               is_jmp0;
    logic               is_jmp1;

    // Memory keeps words with the byte order reversed.
    function automatic logic [`WORD_W-1:0] byte_rev(input logic [`WORD_W-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign en_jmp   = en_jmp0 | en_jmp1;
    assign jmp_addr = en_jmp0 ? jmp_addr0 : jmp_addr1;  // Slot 0 wins.

    assign wordx = byte_rev(instx);
    assign wordy = byte_rev(insty);

    // JAL, or JALR with funct3 zero.
    assign is_jmp0 = hitx && (wordx[6:0] == 7'b1101111 ||
                              (wordx[6:0] == 7'b1100111 && wordx[14:12] == 3'b000));
    assign is_jmp1 = hity && (wordy[6:0] == 7'b1101111 ||
                              (wordy[6:0] == 7'b1100111 && wordy[14:12] == 3'b000));

    always_ff @(posedge clk) begin
        if (rst) begin
            jmp_stall <= 1'b0;
            pcx       <= `RESET_PC;
            pcy       <= `RESET_PC + 4;
            pc0       <= `RESET_PC;
            pc1       <= `RESET_PC + 4;
            hitx_q    <= 1'b0;
            hity_q    <= 1'b0;
            instx_q   <= `OP_NOP;
            insty_q   <= `OP_NOP;
        end else if (rdy) begin
            if (en_jmp) begin
                // Redirect with two bubbles.
                jmp_stall <= 1'b0;
                pcx       <= jmp_addr;
                pcy       <= jmp_addr + 4;
                pc0       <= jmp_addr;
                pc1       <= jmp_addr + 4;
                hitx_q    <= 1'b0;
                hity_q    <= 1'b0;
                instx_q   <= `OP_NOP;
                insty_q   <= `OP_NOP;
            end else if (issue0 && issue1) begin
                pc0 <= pcx;
                pc1 <= pcy;
                if (hitx && !jmp_stall) begin
                    hitx_q  <= 1'b1;
                    instx_q <= wordx;
                    hity_q  <= hity;
                    insty_q <= (hity && !is_jmp0) ? wordy : `OP_NOP;
                    pcx     <= pcx + (hity ? 8 : 4);
                    pcy     <= pcy + (hity ? 8 : 4);
                    if (is_jmp0 || is_jmp1) begin
                        jmp_stall <= 1'b1;
                    end
                end else begin
                    // Miss or waiting on a redirect. PCs hold.
                    hitx_q  <= 1'b0;
                    hity_q  <= 1'b0;
                    instx_q <= `OP_NOP;
                    insty_q <= `OP_NOP;
                end
            end
        end
    end

    // A redirect only answers a jump that this stage has already let through.
    a_jmp_after_stall: assert property (@(posedge clk) disable iff (rst)
        (en_jmp0 || en_jmp1) |-> jmp_stall);

endmodule

//--- design/decoder.sv
`include "rv_front_config.svh"

module decoder import rv_front_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               issue,
    output logic               issue0,
    output logic               issue1,
    // From fetch.
    input  logic [`ADDR_W-1:0] pc0,
    input  logic [`ADDR_W-1:0] pc1,
    input  logic               hitx_q,
    input  logic               hity_q,
    input  logic [`WORD_W-1:0] instx_q,
    input  logic [`WORD_W-1:0] insty_q,
    // Decoded pair.
    output logic               slot0_valid,
    output logic [`ADDR_W-1:0] slot0_pc,
    output op_class_e          slot0_op,
    output logic [4:0]         slot0_rd,
    output logic [`WORD_W-1:0] slot0_imm,
    output logic               slot1_valid,
    output logic [`ADDR_W-1:0] slot1_pc,
    output op_class_e          slot1_op,
    output logic [4:0]         slot1_rd,
    output logic [`WORD_W-1:0] slot1_imm
);

    function automatic op_class_e classify(input logic [`WORD_W-1:0] w);
        op_class_e c;
        if (w == `OP_NOP) begin
            c = OPC_NOP;
        end else begin
            case (w[6:0])
                7'b0110011, 7'b0010011: c = OPC_ALU;
                7'b0000011:             c = OPC_LOAD;
                7'b0100011:             c = OPC_STORE;
                7'b1100011:             c = OPC_BRANCH;
                7'b1101111:             c = OPC_JAL;
                7'b1100111:             c = OPC_JALR;
                default:                c = OPC_OTHER;
            endcase
        end
        return c;
    endfunction

    // J-type for JAL, I-type for the rest.
    function automatic logic [`WORD_W-1:0] imm_of(input logic [`WORD_W-1:0] w);
        if (w[6:0] == 7'b1101111) begin
            return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        return {{20{w[31]}}, w[31:20]};
    endfunction

    // Pairs are never split.
    assign issue0 = issue;
    assign issue1 = issue;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot0_valid <= 1'b0;
            slot0_pc    <= '0;
            slot0_op    <= OPC_NOP;
            slot0_rd    <= '0;
            slot0_imm   <= '0;
            slot1_valid <= 1'b0;
            slot1_pc    <= '0;
            slot1_op    <= OPC_NOP;
            slot1_rd    <= '0;
            slot1_imm   <= '0;
        end else if (rdy && issue) begin
            slot0_valid <= hitx_q && (instx_q != `OP_NOP);
            slot0_pc    <= pc0;
            slot0_op    <= classify(instx_q);
            slot0_rd    <= instx_q[11:7];
            slot0_imm   <= imm_of(instx_q);
            slot1_valid <= hity_q && (insty_q != `OP_NOP);
            slot1_pc    <= pc1;
            slot1_op    <= classify(insty_q);
            slot1_rd    <= insty_q[11:7];
            slot1_imm   <= imm_of(insty_q);
        end
    end

endmodule

//--- design/branch_unit.sv
`include "rv_front_config.svh"

module branch_unit import rv_front_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               slot0_valid,
    input  logic [`ADDR_W-1:0] slot0_pc,
    input  op_class_e          slot0_op,
    input  logic [`WORD_W-1:0] slot0_imm,
    input  logic               slot1_valid,
    input  logic [`ADDR_W-1:0] slot1_pc,
    input  op_class_e          slot1_op,
    input  logic [`WORD_W-1:0] slot1_imm,
    output logic               en_jmp0,
    output logic [`ADDR_W-1:0] jmp_addr0,
    output logic               en_jmp1,
    output logic [`ADDR_W-1:0] jmp_addr1
);

    logic jump0;
    logic jump1;
    logic jmp_done;  // Jump on the slots already sent.

    assign jump0 = slot0_valid && (slot0_op == OPC_JAL || slot0_op == OPC_JALR);
    assign jump1 = slot1_valid && (slot1_op == OPC_JAL || slot1_op == OPC_JALR);

    always_ff @(posedge clk) begin
        if (rst) begin
            en_jmp0  <= 1'b0;
            en_jmp1  <= 1'b0;
            jmp_done <= 1'b0;
        end else if (rdy) begin
            en_jmp0  <= jump0 && !jmp_done;
            en_jmp1  <= jump1 && !jmp_done;
            jmp_done <= jump0 || jump1;  // Held pair fires once.
        end
    end

    // JALR base is x0.
    always_ff @(posedge clk) begin
        if (rdy) begin
            jmp_addr0 <= (slot0_op == OPC_JALR) ? {slot0_imm[`ADDR_W-1:1], 1'b0}
                                                : slot0_pc + slot0_imm;
            jmp_addr1 <= (slot1_op == OPC_JALR) ? {slot1_imm[`ADDR_W-1:1], 1'b0}
                                                : slot1_pc + slot1_imm;
        end
    end

    // Fetch squashes slot 1 behind a jump in slot 0.
    a_one_redirect: assert property (@(posedge clk) disable iff (rst)
        !(en_jmp0 && en_jmp1));

endmodule

//--- design/rv_front_top.sv
`include "rv_front_config.svh"

module rv_front_top import rv_front_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               issue,
    // Refill memory.
    output logic               mem_req,
    output logic [`ADDR_W-1:0] mem_addr,
    input  logic               mem_valid,
    input  logic [`WORD_W-1:0] mem_data,
    // Decoded pair.
    output logic               slot0_valid,
    output logic [`ADDR_W-1:0] slot0_pc,
    output op_class_e          slot0_op,
    output logic [4:0]         slot0_rd,
    output logic [`WORD_W-1:0] slot0_imm,
    output logic               slot1_valid,
    output logic [`ADDR_W-1:0] slot1_pc,
    output op_class_e          slot1_op,
    output logic [4:0]         slot1_rd,
    output logic [`WORD_W-1:0] slot1_imm,
    output logic               redirect,
    output logic [`ADDR_W-1:0] redirect_addr
);

    logic [`ADDR_W-1:0] pcx;
    logic [`ADDR_W-1:0] pcy;
    logic               hitx;
    logic               hity;
    logic [`WORD_W-1:0] instx;
    logic [`WORD_W-1:0] insty;
    logic               en_jmp0;
    logic [`ADDR_W-1:0] jmp_addr0;
    logic               en_jmp1;
    logic [`ADDR_W-1:0] jmp_addr1;
    logic               issue0;
    logic               issue1;
    logic [`ADDR_W-1:0] pc0;
    logic [`ADDR_W-1:0] pc1;
    logic               hitx_q;
    logic               hity_q;
    logic [`WORD_W-1:0] instx_q;
    logic [`WORD_W-1:0] insty_q;

    assign redirect      = en_jmp0 | en_jmp1;
    assign redirect_addr = en_jmp0 ? jmp_addr0 : jmp_addr1;  // Same priority as fetch.

    icache icache_inst (
        .clk(clk), .rst(rst), .rdy(rdy),
        .pcx(pcx), .pcy(pcy),
        .hitx(hitx), .hity(hity), .instx(instx), .insty(insty),
        .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_valid(mem_valid), .mem_data(mem_data)
    );

    cpu_if cpu_if_inst (
        .clk(clk), .rst(rst), .rdy(rdy),
        .hitx(hitx), .hity(hity), .instx(instx), .insty(insty),
        .pcx(pcx), .pcy(pcy),
        .en_jmp0(en_jmp0), .jmp_addr0(jmp_addr0),
        .en_jmp1(en_jmp1), .jmp_addr1(jmp_addr1),
        .issue0(issue0), .issue1(issue1),
        .pc0(pc0), .pc1(pc1), .hitx_q(hitx_q), .hity_q(hity_q),
        .instx_q(instx_q), .insty_q(insty_q)
    );

    decoder decoder_inst (
        .clk(clk), .rst(rst), .rdy(rdy), .issue(issue),
        .issue0(issue0), .issue1(issue1),
        .pc0(pc0), .pc1(pc1), .hitx_q(hitx_q), .hity_q(hity_q),
        .instx_q(instx_q), .insty_q(insty_q),
        .slot0_valid(slot0_valid), .slot0_pc(slot0_pc), .slot0_op(slot0_op),
        .slot0_rd(slot0_rd), .slot0_imm(slot0_imm),
        .slot1_valid(slot1_valid), .slot1_pc(slot1_pc), .slot1_op(slot1_op),
        .slot1_rd(slot1_rd), .slot1_imm(slot1_imm)
    );

    branch_unit branch_unit_inst (
        .clk(clk), .rst(rst), .rdy(rdy),
        .slot0_valid(slot0_valid), .slot0_pc(slot0_pc),
        .slot0_op(slot0_op), .slot0_imm(slot0_imm),
        .slot1_valid(slot1_valid), .slot1_pc(slot1_pc),
        .slot1_op(slot1_op), .slot1_imm(slot1_imm),
        .en_jmp0(en_jmp0), .jmp_addr0(jmp_addr0),
        .en_jmp1(en_jmp1), .jmp_addr1(jmp_addr1)
    );

endmodule

//--- verif/tb_rv_front.sv
`include "rv_front_config.svh"

module tb_rv_front import rv_front_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          PROG_WORDS = 128;
    localparam logic [31:0] PROG_BYTES = PROG_WORDS * 4;
    localparam int          JUMPS      = 4;   // Taken jumps per pass.
    localparam int          PASSES     = 2;
    localparam int          WORST_FILL = 16;  // Cycles per word, refill plus drops.
    localparam int          TIMEOUT    = PASSES * PROG_WORDS * WORST_FILL;

    logic               clk = 1'b0;
    logic               rst;
    logic               rdy;
    logic               issue;
    logic               mem_req;
    logic [`ADDR_W-1:0] mem_addr;
    logic               mem_valid;
    logic [`WORD_W-1:0] mem_data;
    logic               slot0_valid;
    logic [`ADDR_W-1:0] slot0_pc;
    op_class_e          slot0_op;
    logic [4:0]         slot0_rd;
    logic [`WORD_W-1:0] slot0_imm;
    logic               slot1_valid;
    logic [`ADDR_W-1:0] slot1_pc;
    op_class_e          slot1_op;
    logic [4:0]         slot1_rd;
    logic [`WORD_W-1:0] slot1_imm;
    logic               redirect;
    logic [`ADDR_W-1:0] redirect_addr;

    // Program image and what each word should decode to.
    logic [`WORD_W-1:0] mem_image [PROG_WORDS];
    op_class_e          prog_op   [PROG_WORDS];
    logic [4:0]         prog_rd   [PROG_WORDS];
    logic [`ADDR_W-1:0] prog_tgt  [PROG_WORDS];
    bit                 seen_fill [PROG_WORDS];

    int                 mem_wait;
    int                 errors = 0;
    int                 cycles = 0;
    int                 redirects;
    logic               fresh;      // Slot outputs were loaded at the last edge.
    logic               pend_jump;
    logic [`ADDR_W-1:0] pend_tgt;
    logic [`ADDR_W-1:0] exp_pc;

    rv_front_top rv_front_top_inst (.*);

    always #4 clk = ~clk;

    function automatic int word_of(input logic [`ADDR_W-1:0] pc);
        return int'(pc[`ADDR_W-1:2] % PROG_WORDS);
    endfunction

    function automatic op_class_e op_at(input logic [`ADDR_W-1:0] pc);
        if (pc >= PROG_BYTES || pc[1:0] != 2'b00) begin
            return OPC_NOP;  // Never the class of a valid slot.
        end
        return prog_op[word_of(pc)];
    endfunction

    function automatic bit is_jump(input op_class_e op);
        return op == OPC_JAL || op == OPC_JALR;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("At %0t: %s", $time, what);
    endtask

    task automatic place_jal(input logic [`ADDR_W-1:0] pc, input logic [`ADDR_W-1:0] tgt);
        logic [20:0]        off;
        logic [`WORD_W-1:0] w;
        off = 21'(tgt - pc);
        w   = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
        prog_op[word_of(pc)]   = OPC_JAL;
        prog_rd[word_of(pc)]   = 5'd1;
        prog_tgt[word_of(pc)]  = tgt;
        mem_image[word_of(pc)] = {<<8{w}};
    endtask

    task automatic place_jalr(input logic [`ADDR_W-1:0] pc, input logic [`ADDR_W-1:0] tgt);
        logic [`WORD_W-1:0] w;
        w = {tgt[11:0], 5'd0, 3'b000, 5'd0, 7'b1100111};  // Base x0.
        prog_op[word_of(pc)]   = OPC_JALR;
        prog_rd[word_of(pc)]   = 5'd0;
        prog_tgt[word_of(pc)]  = tgt;
        mem_image[word_of(pc)] = {<<8{w}};
    endtask

    // ==============================
    // Program
    // ==============================

    task automatic load_program();
        logic [`WORD_W-1:0] w;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_op[i]   = OPC_ALU;
            prog_rd[i]   = 5'(1 + i % 31);  // Never x0, so never the NOP word.
            prog_tgt[i]  = '0;
            w            = {12'(i * 4), 5'd0, 3'b000, prog_rd[i], 7'b0010011};
            mem_image[i] = {<<8{w}};        // Memory holds words byte-reversed.
        end
        place_jal(32'h040, 32'h080);
        place_jal(32'h0a4, 32'h0c0);
        place_jal(32'h150, 32'h1c8);
        place_jalr(32'h1ec, 32'h000);       // Back to the start.
    endtask

    // One step of the refill memory, at each drive point.
    task automatic serve_memory();
        mem_valid = 1'b0;
        if (mem_wait > 0) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                mem_valid = 1'b1;
                mem_data  = mem_image[word_of(mem_addr)];
                seen_fill[word_of(mem_addr)] = 1'b1;
            end
        end else if (mem_req) begin
            mem_wait = $urandom_range(6, 1);
        end
    endtask

    initial begin
        void'($urandom(32'h8217));
        rst       = 1'b1;
        rdy       = 1'b0;
        issue     = 1'b0;
        mem_valid = 1'b0;
        mem_data  = '0;
        mem_wait  = 0;
        load_program();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        forever begin
            rdy   = ($urandom_range(7, 0) != 0);
            issue = ($urandom_range(3, 0) != 0);
            serve_memory();
            @(posedge clk);
            #1;
        end
    end

    // Expected pc and pending jump.
    always @(posedge clk) begin
        if (rst) begin
            fresh     <= 1'b0;
            exp_pc    <= `RESET_PC;
            pend_jump <= 1'b0;
            pend_tgt  <= '0;
            redirects <= 0;
        end else begin
            fresh <= rdy && issue;
            if (redirect && rdy) begin
                exp_pc    <= pend_tgt;
                pend_jump <= 1'b0;
                redirects <= redirects + 1;
            end else if (fresh && slot1_valid) begin
                exp_pc <= slot1_pc + 4;
            end else if (fresh && slot0_valid) begin
                exp_pc <= slot0_pc + 4;
            end
            if (fresh && slot0_valid && is_jump(slot0_op)) begin
                pend_jump <= 1'b1;
                pend_tgt  <= prog_tgt[word_of(slot0_pc)];
            end else if (fresh && slot1_valid && is_jump(slot1_op)) begin
                pend_jump <= 1'b1;
                pend_tgt  <= prog_tgt[word_of(slot1_pc)];
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    a_seq0: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot0_valid) |-> slot0_pc == exp_pc)
        else report_mismatch("slot0_pc", $sampled(slot0_pc), $sampled(exp_pc));
    a_seq1: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot1_valid) |-> slot0_valid && slot1_pc == slot0_pc + 4)
        else report_mismatch("slot1_pc", $sampled(slot1_pc), $sampled(slot0_pc) + 4);

    a_op0: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot0_valid) |-> slot0_op == op_at(slot0_pc))
        else report_mismatch("slot0_op", $sampled(slot0_op), op_at($sampled(slot0_pc)));
    a_op1: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot1_valid) |-> slot1_op == op_at(slot1_pc))
        else report_mismatch("slot1_op", $sampled(slot1_op), op_at($sampled(slot1_pc)));

    // ALU words carry their own address.
    a_imm0: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot0_valid && slot0_op == OPC_ALU) |-> slot0_imm == slot0_pc)
        else report_mismatch("slot0_imm", $sampled(slot0_imm), $sampled(slot0_pc));
    a_imm1: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot1_valid && slot1_op == OPC_ALU) |-> slot1_imm == slot1_pc)
        else report_mismatch("slot1_imm", $sampled(slot1_imm), $sampled(slot1_pc));

    a_rd0: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot0_valid) |-> slot0_rd == prog_rd[word_of(slot0_pc)])
        else report_mismatch("slot0_rd", $sampled(slot0_rd),
                             prog_rd[word_of($sampled(slot0_pc))]);
    a_rd1: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot1_valid) |-> slot1_rd == prog_rd[word_of(slot1_pc)])
        else report_mismatch("slot1_rd", $sampled(slot1_rd),
                             prog_rd[word_of($sampled(slot1_pc))]);

    a_jal_imm: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot0_valid && slot0_op == OPC_JAL)
            |-> slot0_pc + slot0_imm == prog_tgt[word_of(slot0_pc)])
        else report_mismatch("slot0_imm", $sampled(slot0_imm),
                             prog_tgt[word_of($sampled(slot0_pc))] - $sampled(slot0_pc));

    a_filled0: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot0_valid) |-> seen_fill[word_of(slot0_pc)])
        else note_failure("slot 0 valid at a pc that memory never returned");
    a_filled1: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot1_valid) |-> seen_fill[word_of(slot1_pc)])
        else note_failure("slot 1 valid at a pc that memory never returned");

    a_squash: assert property (@(posedge clk) disable iff (rst)
        (fresh && slot0_valid && is_jump(slot0_op)) |-> !slot1_valid)
        else report_mismatch("slot1_valid", $sampled(slot1_valid), 0);

    a_redirect_cause: assert property (@(posedge clk) disable iff (rst)
        redirect |-> pend_jump)
        else note_failure("redirect raised with no jump pending");
    a_redirect_addr: assert property (@(posedge clk) disable iff (rst)
        redirect |-> redirect_addr == pend_tgt)
        else report_mismatch("redirect_addr", $sampled(redirect_addr), $sampled(pend_tgt));

    a_hold: assert property (@(posedge clk) disable iff (rst)
        !fresh |-> $stable({slot0_valid, slot0_pc, slot0_op, slot0_rd, slot0_imm})
                   && $stable({slot1_valid, slot1_pc, slot1_op, slot1_rd, slot1_imm}))
        else note_failure("slot outputs changed while issue or rdy was low");

    a_mem_addr: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> mem_addr[1:0] == 2'b00 && mem_addr < PROG_BYTES)
        else note_failure($sformatf("mem_addr %h is unaligned or outside the program",
                                    $sampled(mem_addr)));

    // ==============================
    // End of run
    // ==============================

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Run stopped after %0d cycles without finishing the program", cycles);
            $display("Checks failed: %0d, redirects seen: %0d", errors, redirects);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        wait (rst === 1'b0);
        wait (redirects == PASSES * JUMPS);
        do begin
            @(posedge clk);
        end while (!(fresh && slot0_valid));  // First slot back at the start.
        repeat (2) @(posedge clk);
        $display("Checks failed: %0d, redirects seen: %0d", errors, redirects);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+design
design/rv_front_pkg.sv
design/icache.sv
design/cpu_if.sv
design/decoder.sv
design/branch_unit.sv
design/rv_front_top.sv
verif/tb_rv_front.sv

//--- Bender.yml
package:
  name: rv_front

sources:
  - include_dirs:
      - design
    files:
      - design/rv_front_pkg.sv
      - design/icache.sv
      - design/cpu_if.sv
      - design/decoder.sv
      - design/branch_unit.sv
      - design/rv_front_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_rv_front.sv
